//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f verilog.f --top-module controlPath_tb -o simControlPath
	@out="$$(./obj_dir/simControlPath)"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

//--- hdl/aluDecoder.sv
`timescale 1ns/100ps
module aluDecoder (
  input  logic          aluOpFlag,
  input  logic [3:0]    opcode,
  input  logic          setFlags,
  output ctrlPkg::aluOp aluOperation,
  output logic [1:0]    flagWrite,
  output logic          noRegWrite
);
  import ctrlPkg::*;

  logic logicalOp;
  logic updateFlags;

  always_comb begin
    if (!aluOpFlag) begin
      aluOperation = opAdd;  // Address and target arithmetic
    end else begin
      case (opcode)
        4'b0000, 4'b1000: aluOperation = opAnd;  // AND, TST
        4'b0001, 4'b1001: aluOperation = opEor;  // EOR, TEQ
        4'b0010, 4'b0110: aluOperation = opSub;  // SUB, SBC
        4'b0011, 4'b0111: aluOperation = opRsb;  // RSB, RSC
        4'b1010:          aluOperation = opCmp;
        4'b1100:          aluOperation = opOrr;
        4'b1101:          aluOperation = opMov;
        4'b1110:          aluOperation = opBic;
        4'b1111:          aluOperation = opMvn;
        default:          aluOperation = opAdd;  // ADD, ADC, CMN
      endcase
    end
  end

  // TST, TEQ, CMP and CMN only touch flags
  assign noRegWrite = aluOpFlag & (opcode[3:2] == 2'b10);

  assign logicalOp = aluOperation inside {opAnd, opOrr, opEor, opBic, opMov, opMvn};
  assign updateFlags = aluOpFlag & (setFlags | noRegWrite);

  // Bit 1 covers NZ, bit 0 covers CV
  assign flagWrite[1] = updateFlags;
  assign flagWrite[0] = updateFlags & ~logicalOp;  // Logic ops keep C and V

endmodule

//--- hdl/condUnit.sv
`timescale 1ns/100ps
module condUnit (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          enable,
  input  ctrlPkg::condCode              cond,
  input  logic [ctrlPkg::FlagWidth-1:0] aluFlags,
  input  logic [1:0]                    flagWrite,
  output logic                          condEx,
  output logic [ctrlPkg::FlagWidth-1:0] savedFlags
);
  import ctrlPkg::*;

  logic neg, zero, carry, overflow;
  logic geFlag;

  assign {neg, zero, carry, overflow} = savedFlags;
  assign geFlag = (neg == overflow);  // Signed greater or equal

  always_comb begin
    case (cond)
      condEq:  condEx = zero;
      condNe:  condEx = ~zero;
      condCs:  condEx = carry;
      condCc:  condEx = ~carry;
      condMi:  condEx = neg;
      condPl:  condEx = ~neg;
      condVs:  condEx = overflow;
      condVc:  condEx = ~overflow;
      condHi:  condEx = carry & ~zero;
      condLs:  condEx = ~carry | zero;
      condGe:  condEx = geFlag;
      condLt:  condEx = ~geFlag;
      condGt:  condEx = ~zero & geFlag;
      condLe:  condEx = zero | ~geFlag;
      condAl:  condEx = 1'b1;
      default: condEx = 1'b0;  // NV never executes
    endcase
  end

  // NZ and CV load separately
  always_ff @(posedge clk) begin
    if (rst) begin
      savedFlags <= '0;
    end else if (condEx && enable) begin
      if (flagWrite[1]) begin
        savedFlags[3:2] <= aluFlags[3:2];
      end
      if (flagWrite[0]) begin
        savedFlags[1:0] <= aluFlags[1:0];
      end
    end
  end

endmodule

//--- hdl/controlPath.sv
`timescale 1ns/100ps
module controlPath (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [ctrlPkg::InstrWidth-1:0] instr,
  input  logic [ctrlPkg::FlagWidth-1:0] flags,
  output logic [1:0]                    regSrc,
  output logic [1:0]                    immSrc,
  output logic                          aluSrc,
  output ctrlPkg::aluOp                 aluOperation,
  output logic                          memWrite,
  output logic                          memToReg,
  output logic                          regWrite,
  output logic                          pcSrc,
  output logic                          branchTaken,
  output logic                          stallFetch,
  output logic                          stallDecode,
  output logic                          flushDecode,
  output logic                          flushExecute
);
  import ctrlPkg::*;

  logic aluSrcD, memToRegD, regWriteD, memWriteD;
  logic branchD, aluOpFlagD, multSelectD, pcWriteD;
  logic [RegAddrWidth-1:0] srcA, srcB, destD, destE;
  logic memToRegE, pcPendingE, pcPendingM;

  instrDecoder i_instrDecoder (
    .instr(instr),
    .regSrc(regSrc),
    .immSrc(immSrc),
    .aluSrc(aluSrcD),
    .memToReg(memToRegD),
    .regWrite(regWriteD),
    .memWrite(memWriteD),
    .branch(branchD),
    .aluOpFlag(aluOpFlagD),
    .multSelect(multSelectD),
    .pcWrite(pcWriteD),
    .srcA(srcA),
    .srcB(srcB),
    .dest(destD)
  );

  // Execute never stalls
  controller i_controller (
    .clk(clk),
    .rst(rst),
    .aluSrcD(aluSrcD),
    .memToRegD(memToRegD),
    .regWriteD(regWriteD),
    .memWriteD(memWriteD),
    .branchD(branchD),
    .aluOpFlagD(aluOpFlagD),
    .multSelectD(multSelectD),
    .pcWriteD(pcWriteD),
    .destD(destD),
    .instr(instr),
    .flags(flags),
    .stallExecute(1'b0),
    .flushExecute(flushExecute),
    .aluSrc(aluSrc),
    .aluOperation(aluOperation),
    .branchTaken(branchTaken),
    .memWrite(memWrite),
    .memToReg(memToReg),
    .regWrite(regWrite),
    .pcSrc(pcSrc),
    .memToRegE(memToRegE),
    .destE(destE),
    .pcPendingE(pcPendingE),
    .pcPendingM(pcPendingM)
  );

  hazardUnit i_hazardUnit (
    .srcA(srcA),
    .srcB(srcB),
    .destE(destE),
    .memToRegE(memToRegE),
    .pcWrite(pcWriteD),
    .pcPendingE(pcPendingE),
    .pcPendingM(pcPendingM),
    .branchTaken(branchTaken),
    .stallFetch(stallFetch),
    .stallDecode(stallDecode),
    .flushDecode(flushDecode),
    .flushExecute(flushExecute)
  );

endmodule

//--- hdl/controller.sv
`timescale 1ns/100ps
module controller (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             aluSrcD,
  input  logic                             memToRegD,
  input  logic                             regWriteD,
  input  logic                             memWriteD,
  input  logic                             branchD,
  input  logic                             aluOpFlagD,
  input  logic                             multSelectD,
  input  logic                             pcWriteD,
  input  logic [ctrlPkg::RegAddrWidth-1:0] destD,
  input  logic [ctrlPkg::InstrWidth-1:0]   instr,
  input  logic [ctrlPkg::FlagWidth-1:0]    flags,
  input  logic                             stallExecute,
  input  logic                             flushExecute,
  output logic                             aluSrc,
  output ctrlPkg::aluOp                    aluOperation,
  output logic                             branchTaken,
  output logic                             memWrite,
  output logic                             memToReg,
  output logic                             regWrite,
  output logic                             pcSrc,
  output logic                             memToRegE,
  output logic [ctrlPkg::RegAddrWidth-1:0] destE,
  output logic                             pcPendingE,
  output logic                             pcPendingM
);
  import ctrlPkg::*;

  logic       regWriteE, memWriteE, branchE, aluOpFlagE, multSelectE, pcWriteE;
  condCode    condE;
  logic [3:0] opcodeE;
  logic       setFlagsE;
  logic [1:0] aluFlagWrite, flagWriteE;
  logic       noRegWrite, condEx;
  logic       regWriteGatedE, memWriteGatedE, pcSrcGatedE;
  logic       memToRegM, regWriteM, pcSrcM;

  // Decode to execute, flush wins over stall
  always_ff @(posedge clk) begin
    if (rst || flushExecute) begin
      {aluSrc, memToRegE, regWriteE, memWriteE} <= '0;
      {branchE, aluOpFlagE, multSelectE, pcWriteE} <= '0;
    end else if (!stallExecute) begin
      {aluSrc, memToRegE, regWriteE, memWriteE} <= {aluSrcD, memToRegD, regWriteD, memWriteD};
      {branchE, aluOpFlagE, multSelectE, pcWriteE} <= {branchD, aluOpFlagD, multSelectD, pcWriteD};
    end
  end

  always_ff @(posedge clk) begin
    if (!stallExecute) begin
      destE     <= destD;
      condE     <= condCode'(instr[31:28]);
      opcodeE   <= instr[24:21];
      setFlagsE <= instr[20];  // S bit
    end
  end

  aluDecoder i_aluDecoder (
    .aluOpFlag(aluOpFlagE),
    .opcode(opcodeE),
    .setFlags(setFlagsE),
    .aluOperation(aluOperation),
    .flagWrite(aluFlagWrite),
    .noRegWrite(noRegWrite)
  );

  // MULS only sets N and Z
  assign flagWriteE = multSelectE ? {setFlagsE, 1'b0} : aluFlagWrite;

  condUnit i_condUnit (
    .clk(clk),
    .rst(rst),
    .enable(~stallExecute),
    .cond(condE),
    .aluFlags(flags),
    .flagWrite(flagWriteE),
    .condEx(condEx),
    .savedFlags()
  );

  assign branchTaken    = branchE & condEx;
  assign regWriteGatedE = regWriteE & condEx & ~noRegWrite;
  assign memWriteGatedE = memWriteE & condEx;
  assign pcSrcGatedE    = pcWriteE & condEx & ~noRegWrite;
  assign pcPendingE     = pcWriteE;  // Before the condition check

  always_ff @(posedge clk) begin
    if (rst) begin
      {memWrite, memToRegM, regWriteM, pcSrcM} <= '0;
      {memToReg, regWrite, pcSrc} <= '0;
    end else begin
      {memWrite, memToRegM, regWriteM, pcSrcM} <=
        {memWriteGatedE, memToRegE, regWriteGatedE, pcSrcGatedE};
      {memToReg, regWrite, pcSrc} <= {memToRegM, regWriteM, pcSrcM};  // Writeback
    end
  end

  assign pcPendingM = pcSrcM;

endmodule

//--- hdl/ctrlPkg.sv
package ctrlPkg;

  localparam int InstrWidth   = 32;
  localparam int FlagWidth    = 4;  // NZCV
  localparam int RegAddrWidth = 4;

  // Decoded instruction class
  typedef enum logic [2:0] {
    clsDataImm,
    clsDataReg,
    clsMultiply,
    clsLoad,
    clsStore,
    clsBranch,
    clsUndefined
  } instrClass;

  // Operation handed to the datapath ALU
  typedef enum logic [3:0] {
    opAdd,
    opSub,
    opRsb,
    opAnd,
    opOrr,
    opEor,
    opBic,
    opMov,
    opMvn,
    opCmp  // Subtract for flags only
  } aluOp;

  // Condition field, instr[31:28]
  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc,
    condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt,
    condGt, condLe, condAl, condNv
  } condCode;

endpackage

//--- hdl/hazardUnit.sv
`timescale 1ns/100ps
module hazardUnit (
  input  logic [ctrlPkg::RegAddrWidth-1:0] srcA,
  input  logic [ctrlPkg::RegAddrWidth-1:0] srcB,
  input  logic [ctrlPkg::RegAddrWidth-1:0] destE,
  input  logic                             memToRegE,
  input  logic                             pcWrite,
  input  logic                             pcPendingE,
  input  logic                             pcPendingM,
  input  logic                             branchTaken,
  output logic                             stallFetch,
  output logic                             stallDecode,
  output logic                             flushDecode,
  output logic                             flushExecute
);

  logic loadUse;
  logic pcPending;

  // Load in E whose result decode wants to read
  assign loadUse = memToRegE & ((srcA == destE) | (srcB == destE));

  // PC write anywhere between decode and memory
  assign pcPending = pcWrite | pcPendingE | pcPendingM;

  // Execute and memory never stall, only decode holds
  assign stallDecode  = loadUse;
  assign stallFetch   = loadUse | pcPending;
  assign flushExecute = loadUse | branchTaken;  // Bubble into E
  assign flushDecode  = branchTaken | pcPending;

endmodule

//--- hdl/instrDecoder.sv
`timescale 1ns/100ps
module instrDecoder (
  input  logic [ctrlPkg::InstrWidth-1:0]   instr,
  output logic [1:0]                       regSrc,
  output logic [1:0]                       immSrc,
  output logic                             aluSrc,
  output logic                             memToReg,
  output logic                             regWrite,
  output logic                             memWrite,
  output logic                             branch,
  output logic                             aluOpFlag,
  output logic                             multSelect,
  output logic                             pcWrite,
  output logic [ctrlPkg::RegAddrWidth-1:0] srcA,
  output logic [ctrlPkg::RegAddrWidth-1:0] srcB,
  output logic [ctrlPkg::RegAddrWidth-1:0] dest
);
  import ctrlPkg::*;

  instrClass  cls;
  logic [10:0] controls;

  always_comb begin
    case (instr[27:25])
      3'b000: begin
        // MUL/MLA carry 1001 in bits 7:4
        if (instr[7:4] == 4'b1001 && instr[24:22] == 3'b000) begin
          cls = clsMultiply;
        end else begin
          cls = clsDataReg;
        end
      end
      3'b001:         cls = clsDataImm;
      3'b010, 3'b011: cls = instr[20] ? clsLoad : clsStore;
      3'b101:         cls = clsBranch;
      default:        cls = clsUndefined;
    endcase
  end

  // regSrc immSrc aluSrc memToReg regWrite memWrite branch aluOpFlag multSelect
  always_comb begin
    case (cls)
      clsDataImm:  controls = 11'b00_00_1_0_1_0_0_1_0;
      clsDataReg:  controls = 11'b00_00_0_0_1_0_0_1_0;
      clsMultiply: controls = 11'b00_00_0_0_1_0_0_0_1;
      clsLoad:     controls = 11'b00_01_1_1_1_0_0_0_0;
      clsStore:    controls = 11'b10_01_1_0_0_1_0_0_0;
      clsBranch:   controls = 11'b01_10_1_0_0_0_1_0_0;
      default:     controls = '0;  // Nothing gets written
    endcase
  end

  assign {regSrc, immSrc, aluSrc, memToReg, regWrite,
          memWrite, branch, aluOpFlag, multSelect} = controls;

  always_comb begin
    srcA = instr[19:16];
    srcB = instr[3:0];
    dest = instr[15:12];
    case (cls)
      clsMultiply: begin
        srcA = instr[3:0];
        srcB = instr[11:8];
        dest = instr[19:16];
      end
      clsDataImm: srcB = instr[19:16];       // Only one register read
      clsLoad:    if (!instr[25]) srcB = instr[19:16];
      clsStore:   srcB = instr[15:12];       // Rd holds the store data
      clsBranch: begin
        srcA = {RegAddrWidth{1'b1}};  // PC
        srcB = {RegAddrWidth{1'b1}};
      end
      default: ;
    endcase
  end

  assign pcWrite = branch | (regWrite & (dest == {RegAddrWidth{1'b1}}));

endmodule

//--- verif/controlPath_stimulus.txt
// test instr flags(NZCV for the instruction in execute)
// outputs: regSrc immSrc aluSrc aluOp branchTaken memWrite memToReg regWrite pcSrc; hazards: stallFetch stallDecode flushDecode flushExecute
01 E2801005 0 000000000 0000
01 E0812000 0 001000000 0000
01 E0030291 0 000000000 0000
01 E5904004 0 010000010 0000
01 E5802008 0 211000010 0000
01 EC000000 0 001000010 0000
01 EC000000 0 000001110 0000
01 EC000000 0 000000000 0000
02 E0515001 0 000000000 0000
02 02806001 4 000100000 0000
02 05802008 0 211000000 0000
02 E1510002 0 001000010 0000
02 02807001 0 000901010 0000
02 05802008 0 211000000 0000
02 EC000000 0 001000000 0000
02 EC000000 0 000000000 0000
02 EC000000 0 000000000 0000
03 E5901004 0 010000000 0000
03 E0812000 0 001000000 1101
03 E0812000 0 000000000 0000
03 EC000000 0 000000110 0000
03 EC000000 0 000000000 0000
03 EC000000 0 000000010 0000
04 EA000002 0 120000000 1010
04 EC000000 0 001010000 1011
04 EC000000 0 000000000 1010
04 EC000000 0 000000001 0000
04 EC000000 0 000000000 0000
05 E280F008 0 000000000 1010
05 EC000000 0 001000000 1010
05 EC000000 0 000000000 1010
05 EC000000 0 000000011 0000
05 EC000000 0 000000000 0000
ff 0 0 0 0

//--- verif/controlPath_sva.sv
`timescale 1ns/100ps
module controlPath_sva (
  input logic                           clk,
  input logic                           rst,
  input logic [ctrlPkg::InstrWidth-1:0] instr,
  input logic                           flushExecute,
  input logic                           memToRegE,
  input logic                           aluSrc,
  input logic                           regWriteE,
  input logic                           memWriteE,
  input logic                           branchE,
  input logic                           pcWriteE,
  input logic                           condEx,
  input logic                           regWriteM
);

  // A load-use bubble means decode keeps its instruction
  property decodeHeld;
    @(posedge clk) disable iff (rst)
      (memToRegE && flushExecute) |=> $stable(instr);
  endproperty

  property flushClearsExecute;
    @(posedge clk) disable iff (rst)
      flushExecute |=> !(aluSrc || memToRegE || regWriteE || memWriteE || branchE || pcWriteE);
  endproperty

  // A skipped instruction reaches memory without its register write
  property noWriteWhenSkipped;
    @(posedge clk) disable iff (rst)
      !condEx |=> !regWriteM;
  endproperty

  assert property (decodeHeld) else $error("decode changed during a load-use stall");
  assert property (flushClearsExecute) else $error("execute controls survived a flush");
  assert property (noWriteWhenSkipped) else $error("register write with condition false");

endmodule

bind controller controlPath_sva i_controlPathSva (
  .clk(clk),
  .rst(rst),
  .instr(instr),
  .flushExecute(flushExecute),
  .memToRegE(memToRegE),
  .aluSrc(aluSrc),
  .regWriteE(regWriteE),
  .memWriteE(memWriteE),
  .branchE(branchE),
  .pcWriteE(pcWriteE),
  .condEx(condEx),
  .regWriteM(regWriteM)
);

//--- verif/controlPath_tb.sv
`timescale 1ns/100ps
module controlPath_tb;
  import ctrlPkg::*;

  localparam int MaxLines  = 64;
  localparam int Fields    = 5;  // Test, instr, flags, outputs, hazards
  localparam int ClkPeriod = 4;
  localparam logic [InstrWidth-1:0] NopInstr = 32'hEC000000;  // Undefined class, writes nothing

  logic clk;
  logic rst;
  logic [InstrWidth-1:0] instr;
  logic [FlagWidth-1:0] flags;
  logic [1:0] regSrc, immSrc;
  logic aluSrc, memWrite, memToReg, regWrite, pcSrc, branchTaken;
  logic stallFetch, stallDecode, flushDecode, flushExecute;
  aluOp aluOperation;

  logic [63:0] stim [0:MaxLines*Fields-1];
  logic [63:0] word;
  logic [35:0] expOut;
  logic [15:0] expHaz;
  logic [7:0]  curTest;
  logic        loaded = 1'b0;
  int numLines, lineIdx, errors, testErrors, testsRun, testsFailed;

  string outNames [0:8] = '{"regSrc", "immSrc", "aluSrc", "aluOperation", "branchTaken",
                            "memWrite", "memToReg", "regWrite", "pcSrc"};
  string hazNames [0:3] = '{"stallFetch", "stallDecode", "flushDecode", "flushExecute"};

  controlPath i_controlPath (
    .clk(clk), .rst(rst), .instr(instr), .flags(flags),
    .regSrc(regSrc), .immSrc(immSrc), .aluSrc(aluSrc), .aluOperation(aluOperation),
    .memWrite(memWrite), .memToReg(memToReg), .regWrite(regWrite), .pcSrc(pcSrc),
    .branchTaken(branchTaken), .stallFetch(stallFetch), .stallDecode(stallDecode),
    .flushDecode(flushDecode), .flushExecute(flushExecute)
  );

  always #2 clk = ~clk;  // 4 ns period

  function automatic logic [63:0] readField(input int line, input int k);
    logic [8:0] idx;
    idx = 9'(line * Fields + k);
    return stim[idx];
  endfunction

  // One hex digit per signal, same order as the data file
  function automatic logic [35:0] packOutputs();
    return {2'b00, regSrc, 2'b00, immSrc, 3'b000, aluSrc, aluOperation,
            3'b000, branchTaken, 3'b000, memWrite, 3'b000, memToReg,
            3'b000, regWrite, 3'b000, pcSrc};
  endfunction

  function automatic logic [15:0] packHazards();
    return {3'b000, stallFetch, 3'b000, stallDecode, 3'b000, flushDecode, 3'b000, flushExecute};
  endfunction

  task automatic compareAll(input logic [35:0] expOut, input logic [15:0] expHaz);
    logic [35:0] gotOut;
    logic [15:0] gotHaz;
    gotOut = packOutputs();
    gotHaz = packHazards();
    for (int k = 0; k < 9; k++) begin
      if (gotOut[(8-k)*4 +: 4] !== expOut[(8-k)*4 +: 4]) begin
        $display("mismatch at %0t ns: %s is %0h, expected %0h (line %0d)", $time,
                 outNames[k], gotOut[(8-k)*4 +: 4], expOut[(8-k)*4 +: 4], lineIdx + 1);
        errors++;
        testErrors++;
      end
    end
    for (int k = 0; k < 4; k++) begin
      if (gotHaz[(3-k)*4 +: 4] !== expHaz[(3-k)*4 +: 4]) begin
        $display("mismatch at %0t ns: %s is %0h, expected %0h (line %0d)", $time,
                 hazNames[k], gotHaz[(3-k)*4 +: 4], expHaz[(3-k)*4 +: 4], lineIdx + 1);
        errors++;
        testErrors++;
      end
    end
  endtask

  task automatic reportTest(input logic [7:0] num);
    testsRun++;
    if (testErrors != 0) begin
      testsFailed++;
      $display("test %0d finished with %0d errors", num, testErrors);
    end else begin
      $display("test %0d finished ok", num);
    end
    testErrors = 0;
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    instr = NopInstr;
    flags = '0;
    errors = 0;
    testErrors = 0;
    testsRun = 0;
    testsFailed = 0;
    lineIdx = 0;
    foreach (stim[i]) stim[i] = '1;
    $readmemh("verif/controlPath_stimulus.txt", stim);
    numLines = 0;
    word = readField(0, 0);
    while (numLines < MaxLines && word[7:0] != 8'hff) begin
      numLines++;
      word = readField(numLines, 0);
    end
    if (numLines == 0) begin
      $display("no stimulus lines were read from the data file");
      errors++;
    end
    loaded = 1'b1;

    repeat (2) @(posedge clk);
    @(negedge clk);
    compareAll('0, '0);  // Test 0, still in reset
    reportTest(8'd0);
    rst = 1'b0;

    for (lineIdx = 0; lineIdx < numLines; lineIdx++) begin
      word = readField(lineIdx, 0);
      curTest = word[7:0];
      word = readField(lineIdx, 1);
      instr = word[InstrWidth-1:0];
      word = readField(lineIdx, 2);
      flags = word[FlagWidth-1:0];
      word = readField(lineIdx, 3);
      expOut = word[35:0];
      word = readField(lineIdx, 4);
      expHaz = word[15:0];
      @(posedge clk);
      compareAll(expOut, expHaz);
      word = readField(lineIdx + 1, 0);
      if (lineIdx == numLines - 1 || word[7:0] != curTest) begin
        reportTest(curTest);
      end
      @(negedge clk);
    end

    $display("%0d tests run, %0d failed, %0d mismatches", testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the stimulus length
  initial begin
    wait (loaded);
    #((numLines + 12) * ClkPeriod);
    $display("timeout: the stimulus did not finish in the expected time");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- verilog.f
hdl/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/aluDecoder.sv
hdl/condUnit.sv
hdl/hazardUnit.sv
hdl/controller.sv
hdl/controlPath.sv
verif/controlPath_sva.sv
verif/controlPath_tb.sv
